// ==== vec_sequencer.f ====
src/seq_pkg.sv
src/vreg_scoreboard.sv
src/issue_ctrl.sv
src/unit_tracker.sv
src/hazard_table.sv
src/vec_sequencer.sv
testbench/seq_properties.sv
testbench/tb_vec_sequencer.sv

// ==== Makefile ====
# Verilator build and run of the vector sequencer testbench

SRCS := $(filter-out +%,$(shell cat vec_sequencer.f))

.PHONY: run clean

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_vec_sequencer: vec_sequencer.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_vec_sequencer -f vec_sequencer.f

# Pass or fail comes from the log, not from the exit status of the binary
run: obj_dir/Vtb_vec_sequencer
	./obj_dir/Vtb_vec_sequencer | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_vec_sequencer.sv ====
// Vector sequencer testbench

`default_nettype none

module tb_vec_sequencer;

  import seq_pkg::*;

  localparam int unsigned QueueDepth = 2;
  localparam int unsigned NumReqs    = 400;
  // 400 requests, worst case all on one unit of depth 2 with 12-cycle retirement
  localparam int unsigned MaxCycles  = 3000;
  // Few registers so that hazards are frequent
  localparam int unsigned RegPool    = 6;

  // Behavior indices for the report
  localparam int unsigned TId    = 0;
  localparam int unsigned THaz   = 1;
  localparam int unsigned TTable = 2;
  localparam int unsigned TReady = 3;
  localparam int unsigned TRun   = 4;

  logic                     clk_i;
  logic                     rst_ni;
  vreq_t                    req_i;
  logic                     req_valid_i;
  logic                     req_ready_o;
  issue_t                   issue_o;
  logic                     issue_valid_o;
  unit_done_t [NrUnits-1:0] unit_done_i;
  vinsn_set_t               running_o;
  logic                     idle_o;
  vinsn_set_t [NrVInsn-1:0] hazard_table_o;

  // Reference model state, registered view of the DUT
  vinsn_set_t  m_running;
  int unsigned m_cnt    [NrUnits];
  logic        m_rd_vld [NrVRegs];
  vid_t        m_rd_id  [NrVRegs];
  logic        m_wr_vld [NrVRegs];
  vid_t        m_wr_id  [NrVRegs];
  vinsn_set_t  m_table  [NrVInsn];
  issue_t      exp_issue;
  logic        exp_valid;

  // Unit models, in-order queues of issued IDs
  vid_t        fifo_id  [NrUnits][NrVInsn];
  int unsigned fifo_due [NrUnits][NrVInsn];
  int unsigned fifo_cnt [NrUnits];

  int unsigned cycle;
  int unsigned n_sent;
  int unsigned n_accepted;
  int unsigned seed;
  logic        drained;
  int unsigned chk [5];
  int unsigned err [5];
  string       test_name [5];

  vec_sequencer #(
    .QueueDepth (QueueDepth)
  ) u_vec_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .issue_o        (issue_o),
    .issue_valid_o  (issue_valid_o),
    .unit_done_i    (unit_done_i),
    .running_o      (running_o),
    .idle_o         (idle_o),
    .hazard_table_o (hazard_table_o)
  );

  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic unit_e target_unit(input op_e op);
    if (op == OP_MUL || op == OP_MACC) return UNIT_MUL;
    if (op == OP_LOAD) return UNIT_LOAD;
    if (op == OP_STORE) return UNIT_STORE;
    return UNIT_ALU;
  endfunction

  function automatic vid_t lowest_free(input vinsn_set_t run);
    vid_t id;
    logic found;
    id    = '0;
    found = 1'b0;
    for (int unsigned i = 0; i < NrVInsn; i++) begin
      if (!found && !run[i]) begin
        id    = vid_t'(i);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  // Ready needs a free ID and room in the target unit
  function automatic logic expect_ready(input vreq_t req);
    return (m_running != '1) && (m_cnt[target_unit(req.op)] < QueueDepth);
  endfunction

  // Issue that an accept of req would produce from the current lists
  function automatic issue_t ref_issue(input vreq_t req);
    issue_t r;
    r         = '0;
    r.id      = lowest_free(m_running);
    r.unit    = target_unit(req.op);
    r.op      = req.op;
    r.vs1     = req.vs1;
    r.use_vs1 = req.use_vs1;
    r.vs2     = req.vs2;
    r.use_vs2 = req.use_vs2;
    r.vd      = req.vd;
    r.use_vd  = req.use_vd;
    // RAW on the sources
    if (req.use_vs1 && m_wr_vld[req.vs1] && m_running[m_wr_id[req.vs1]])
      r.hazard_vs1[m_wr_id[req.vs1]] = 1'b1;
    if (req.use_vs2 && m_wr_vld[req.vs2] && m_running[m_wr_id[req.vs2]])
      r.hazard_vs2[m_wr_id[req.vs2]] = 1'b1;
    // WAR shows on both source vectors, WAW on vd
    if (req.use_vd && m_rd_vld[req.vd] && m_running[m_rd_id[req.vd]]) begin
      r.hazard_vs1[m_rd_id[req.vd]] = 1'b1;
      r.hazard_vs2[m_rd_id[req.vd]] = 1'b1;
    end
    if (req.use_vd && m_wr_vld[req.vd] && m_running[m_wr_id[req.vd]])
      r.hazard_vd[m_wr_id[req.vd]] = 1'b1;
    return r;
  endfunction

  // One clock edge of the model, from the pre-edge handshake and done pulses
  task automatic advance_model();
    logic       acc;
    vinsn_set_t nxt_run;
    issue_t     nxt_issue;
    acc       = req_valid_i && req_ready_o;
    nxt_issue = ref_issue(req_i);
    nxt_run   = m_running;
    if (acc) begin
      nxt_run[nxt_issue.id] = 1'b1;
      m_cnt[nxt_issue.unit]++;
    end
    for (int unsigned u = 0; u < NrUnits; u++) begin
      if (unit_done_i[u].valid) begin
        nxt_run[unit_done_i[u].id] = 1'b0;
        m_cnt[u]--;
      end
    end
    // Row of the instruction now on the issue port
    if (exp_valid)
      m_table[exp_issue.id] = exp_issue.hazard_vs1 | exp_issue.hazard_vs2 | exp_issue.hazard_vd;
    for (int unsigned i = 0; i < NrVInsn; i++) m_table[i] &= nxt_run;
    // Entries of retired IDs expire
    for (int unsigned v = 0; v < NrVRegs; v++) begin
      if (!m_running[m_rd_id[v]]) m_rd_vld[v] = 1'b0;
      if (!m_running[m_wr_id[v]]) m_wr_vld[v] = 1'b0;
    end
    if (acc) begin
      if (req_i.use_vd) begin
        m_wr_vld[req_i.vd] = 1'b1;
        m_wr_id[req_i.vd]  = nxt_issue.id;
      end
      if (req_i.use_vs1) begin
        m_rd_vld[req_i.vs1] = 1'b1;
        m_rd_id[req_i.vs1]  = nxt_issue.id;
      end
      if (req_i.use_vs2) begin
        m_rd_vld[req_i.vs2] = 1'b1;
        m_rd_id[req_i.vs2]  = nxt_issue.id;
      end
      n_accepted++;
    end
    m_running = nxt_run;
    exp_issue = nxt_issue;
    exp_valid = acc;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and unit models
  //////////////////////////////////////////////////////////////////////

  function automatic vreq_t random_req();
    vreq_t r;
    r.op      = op_e'(3'($urandom_range(0, 7)));
    r.vs1     = vreg_t'($urandom_range(0, RegPool - 1));
    r.use_vs1 = ($urandom_range(0, 3) != 0);
    r.vs2     = vreg_t'($urandom_range(0, RegPool - 1));
    r.use_vs2 = ($urandom_range(0, 3) != 0);
    r.vd      = vreg_t'($urandom_range(0, RegPool - 1));
    r.use_vd  = ($urandom_range(0, 3) != 0);
    return r;
  endfunction

  // Retire the head of each unit queue when due, take in the new issue
  task automatic drive_units();
    unit_done_t [NrUnits-1:0] done_vec;
    done_vec = '0;
    for (int unsigned u = 0; u < NrUnits; u++) begin
      if (fifo_cnt[u] != 0 && fifo_due[u][0] <= cycle) begin
        done_vec[u].valid = 1'b1;
        done_vec[u].id    = fifo_id[u][0];
        for (int unsigned k = 1; k < NrVInsn; k++) begin
          fifo_id[u][k-1]  = fifo_id[u][k];
          fifo_due[u][k-1] = fifo_due[u][k];
        end
        fifo_cnt[u]--;
      end
    end
    unit_done_i <= done_vec;
    if (issue_valid_o && fifo_cnt[issue_o.unit] < NrVInsn) begin
      fifo_id[issue_o.unit][fifo_cnt[issue_o.unit]]  = issue_o.id;
      fifo_due[issue_o.unit][fifo_cnt[issue_o.unit]] = cycle + $urandom_range(1, 12);
      fifo_cnt[issue_o.unit]++;
    end
  endtask

  always @(posedge clk_i) begin
    cycle++;
    if (rst_ni) begin
      advance_model();
      drive_units();
      // A held request only leaves on a handshake
      if (!req_valid_i || req_ready_o) begin
        if (n_sent < NumReqs && $urandom_range(0, 3) != 0) begin
          req_i       <= random_req();
          req_valid_i <= 1'b1;
          n_sent++;
        end else begin
          req_valid_i <= 1'b0;
        end
      end
      drained <= (n_accepted == NumReqs) && (m_running == '0) && !exp_valid &&
                 (fifo_cnt[0] + fifo_cnt[1] + fifo_cnt[2] + fifo_cnt[3] == 0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////////////////////////

  task automatic flag_error(input int unsigned test, input string msg);
    err[test]++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      chk[TReady]++;
      if (req_ready_o !== expect_ready(req_i))
        flag_error(TReady, $sformatf("req_ready_o %b, expected %b", req_ready_o,
                                     expect_ready(req_i)));
      if (issue_valid_o !== exp_valid)
        flag_error(TReady, $sformatf("issue_valid_o %b, expected %b", issue_valid_o, exp_valid));
      if (issue_valid_o && exp_valid) begin
        chk[TId]++;
        chk[THaz]++;
        if (issue_o.id !== exp_issue.id)
          flag_error(TId, $sformatf("issued ID %0d, expected %0d", issue_o.id, exp_issue.id));
        if ({issue_o.unit, issue_o.op, issue_o.vs1, issue_o.use_vs1, issue_o.vs2,
             issue_o.use_vs2, issue_o.vd, issue_o.use_vd} !==
            {exp_issue.unit, exp_issue.op, exp_issue.vs1, exp_issue.use_vs1, exp_issue.vs2,
             exp_issue.use_vs2, exp_issue.vd, exp_issue.use_vd})
          flag_error(TId, $sformatf("request fields of ID %0d differ", exp_issue.id));
        if (issue_o.hazard_vs1 !== exp_issue.hazard_vs1)
          flag_error(THaz, $sformatf("hazard_vs1 %h, expected %h", issue_o.hazard_vs1,
                                     exp_issue.hazard_vs1));
        if (issue_o.hazard_vs2 !== exp_issue.hazard_vs2)
          flag_error(THaz, $sformatf("hazard_vs2 %h, expected %h", issue_o.hazard_vs2,
                                     exp_issue.hazard_vs2));
        if (issue_o.hazard_vd !== exp_issue.hazard_vd)
          flag_error(THaz, $sformatf("hazard_vd %h, expected %h", issue_o.hazard_vd,
                                     exp_issue.hazard_vd));
      end
      for (int unsigned i = 0; i < NrVInsn; i++) begin
        chk[TTable]++;
        if (hazard_table_o[i] !== m_table[i])
          flag_error(TTable, $sformatf("table row %0d %h, expected %h", i, hazard_table_o[i],
                                       m_table[i]));
      end
      chk[TRun]++;
      if (running_o !== m_running)
        flag_error(TRun, $sformatf("running_o %h, expected %h", running_o, m_running));
      if (idle_o !== (m_running == '0))
        flag_error(TRun, $sformatf("idle_o %b with running set %h", idle_o, m_running));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////

  initial begin : watchdog
    wait (cycle >= MaxCycles);
    $display("Timeout after %0d cycles with %0d of %0d requests accepted",
             cycle, n_accepted, NumReqs);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int unsigned total_chk;
    int unsigned total_err;
    seed        = $urandom(35);
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    unit_done_i = '0;
    cycle       = 0;
    n_sent      = 0;
    n_accepted  = 0;
    drained     = 1'b0;
    m_running   = '0;
    exp_issue   = '0;
    exp_valid   = 1'b0;
    test_name   = '{"id_alloc", "hazards", "hazard_table", "backpressure", "running_idle"};
    for (int unsigned t = 0; t < 5; t++) begin
      chk[t] = 0;
      err[t] = 0;
    end
    for (int unsigned u = 0; u < NrUnits; u++) begin
      m_cnt[u]    = 0;
      fifo_cnt[u] = 0;
    end
    for (int unsigned v = 0; v < NrVRegs; v++) begin
      m_rd_vld[v] = 1'b0;
      m_rd_id[v]  = '0;
      m_wr_vld[v] = 1'b0;
      m_wr_id[v]  = '0;
    end
    for (int unsigned i = 0; i < NrVInsn; i++) m_table[i] = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    wait (drained);
    // Everything retired, the sequencer must report idle
    @(negedge clk_i);
    chk[TRun]++;
    if (idle_o !== 1'b1) flag_error(TRun, "idle_o low after all units retired");
    total_chk = 0;
    total_err = 0;
    for (int unsigned t = 0; t < 5; t++) begin
      $display("%s: %0d checks, %0d errors", test_name[t], chk[t], err[t]);
      total_chk += chk[t];
      total_err += err[t];
    end
    $display("Summary: %0d requests, %0d checks, %0d errors", n_accepted, total_chk, total_err);
    if (total_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/seq_properties.sv ====
// Sequencer protocol assertions

`default_nettype none

module seq_properties #(
  parameter int unsigned QueueDepth = 2,
  parameter int unsigned CntWidth   = 2
) (
  input logic                                      clk_i,
  input logic                                      rst_ni,
  input logic                                      issue_valid_i,
  input seq_pkg::issue_t                           issue_i,
  input seq_pkg::vinsn_set_t                       running_i,
  input logic                                      idle_i,
  input logic [seq_pkg::NrUnits-1:0][CntWidth-1:0] unit_cnt_i
);

  import seq_pkg::*;

  // A pulse held over two cycles carries a new instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i && $past(issue_valid_i) |-> issue_i.id != $past(issue_i.id))
    else $error("issue pulse held without a new instruction ID");

  // Issued ID shows up as running with the pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i |-> running_i[issue_i.id])
    else $error("issued ID %0d not in the running set", issue_i.id);

  // Idle exactly when no unit holds an instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_i == (unit_cnt_i == '0))
    else $error("idle flag disagrees with the unit occupancy");

  // Occupancy bound per functional unit
  for (genvar u = 0; u < NrUnits; u++) begin : gen_cnt
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      unit_cnt_i[u] <= CntWidth'(QueueDepth))
      else $error("unit %0d holds more than %0d instructions", u, QueueDepth);
  end

endmodule

bind vec_sequencer seq_properties #(
  .QueueDepth (QueueDepth),
  .CntWidth   ($clog2(QueueDepth + 1))
) u_seq_properties (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .issue_valid_i (issue_valid_o),
  .issue_i       (issue_o),
  .running_i     (running_o),
  .idle_i        (idle_o),
  .unit_cnt_i    ({gen_tracker[3].u_unit_tracker.cnt_q,
                   gen_tracker[2].u_unit_tracker.cnt_q,
                   gen_tracker[1].u_unit_tracker.cnt_q,
                   gen_tracker[0].u_unit_tracker.cnt_q})
);

`default_nettype wire

// ==== src/vec_sequencer.sv ====
// Vector instruction sequencer

`default_nettype none

module vec_sequencer #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Dispatcher
  input  seq_pkg::vreq_t                             req_i,
  input  logic                                       req_valid_i,
  output logic                                       req_ready_o,
  // Functional units
  output seq_pkg::issue_t                            issue_o,
  output logic                                       issue_valid_o,
  input  seq_pkg::unit_done_t [seq_pkg::NrUnits-1:0] unit_done_i,
  // Status
  output seq_pkg::vinsn_set_t                        running_o,
  output logic                                       idle_o,
  output seq_pkg::vinsn_set_t [seq_pkg::NrVInsn-1:0] hazard_table_o
);

  import seq_pkg::*;

  logic                     accept;
  vid_t                     new_id;
  logic       [NrUnits-1:0] unit_accept;
  logic       [NrUnits-1:0] unit_full;
  vinsn_set_t               hazard_vs1, hazard_vs2, hazard_vd;
  vinsn_set_t [NrUnits-1:0] unit_running;

  issue_ctrl u_issue_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .running_i     (running_o),
    .unit_full_i   (unit_full),
    .hazard_vs1_i  (hazard_vs1),
    .hazard_vs2_i  (hazard_vs2),
    .hazard_vd_i   (hazard_vd),
    .accept_o      (accept),
    .new_id_o      (new_id),
    .unit_accept_o (unit_accept),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o)
  );

  vreg_scoreboard u_vreg_scoreboard (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .accept_i     (accept),
    .new_id_i     (new_id),
    .running_i    (running_o),
    .hazard_vs1_o (hazard_vs1),
    .hazard_vs2_o (hazard_vs2),
    .hazard_vd_o  (hazard_vd)
  );

  // One tracker per functional unit
  for (genvar u = 0; u < NrUnits; u++) begin : gen_tracker
    unit_tracker #(
      .QueueDepth (QueueDepth)
    ) u_unit_tracker (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .accept_i  (unit_accept[u]),
      .id_i      (new_id),
      .done_i    (unit_done_i[u]),
      .full_o    (unit_full[u]),
      .running_o (unit_running[u])
    );
  end

  hazard_table u_hazard_table (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .unit_running_i (unit_running),
    .issue_i        (issue_o),
    .issue_valid_i  (issue_valid_o),
    .running_o      (running_o),
    .idle_o         (idle_o),
    .hazard_table_o (hazard_table_o)
  );

endmodule

`default_nettype wire

// ==== src/hazard_table.sv ====
// Global running set and hazard table

`default_nettype none

module hazard_table (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  seq_pkg::vinsn_set_t [seq_pkg::NrUnits-1:0] unit_running_i,
  input  seq_pkg::issue_t                           issue_i,
  input  logic                                      issue_valid_i,
  output seq_pkg::vinsn_set_t                       running_o,
  output logic                                      idle_o,
  output seq_pkg::vinsn_set_t [seq_pkg::NrVInsn-1:0] hazard_table_o
);

  import seq_pkg::*;

  vinsn_set_t                running_d;
  vinsn_set_t [NrVInsn-1:0]  table_d;

  // Running anywhere means running in some unit
  always_comb begin
    running_d = '0;
    for (int unsigned u = 0; u < NrUnits; u++) running_d |= unit_running_i[u];
  end

  // Row N lists the instructions that instruction N waits on
  always_comb begin
    table_d = hazard_table_o;
    if (issue_valid_i) begin
      table_d[issue_i.id] = issue_i.hazard_vs1 | issue_i.hazard_vs2 | issue_i.hazard_vd;
    end
    // Drop dependencies on retired instructions
    for (int unsigned id = 0; id < NrVInsn; id++) table_d[id] &= running_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_o      <= '0;
      hazard_table_o <= '0;
    end else begin
      running_o      <= running_d;
      hazard_table_o <= table_d;
    end
  end

  assign idle_o = ~|running_o;

endmodule

`default_nettype wire

// ==== src/unit_tracker.sv ====
// Functional unit occupancy tracker

`default_nettype none

module unit_tracker #(
  parameter int unsigned QueueDepth = 2
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                accept_i,
  input  seq_pkg::vid_t       id_i,
  input  seq_pkg::unit_done_t done_i,
  output logic                full_o,
  output seq_pkg::vinsn_set_t running_o
);

  import seq_pkg::*;

  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  // Instructions currently held by the unit
  typedef logic [CntWidth-1:0] cnt_t;

  cnt_t       cnt_q, cnt_d;
  vinsn_set_t running_q;

  // Up on accept, down on done, hold on both
  always_comb begin
    cnt_d = cnt_q;
    if (accept_i && !done_i.valid) begin
      cnt_d = cnt_q + cnt_t'(1);
    end else if (!accept_i && done_i.valid) begin
      cnt_d = cnt_q - cnt_t'(1);
    end
  end

  assign full_o = (cnt_q == cnt_t'(QueueDepth));

  // Next running set, registered globally by the hazard table
  always_comb begin
    running_o = running_q;
    if (accept_i) running_o[id_i] = 1'b1;
    if (done_i.valid) running_o[done_i.id] = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      running_q <= '0;
    end else begin
      cnt_q     <= cnt_d;
      running_q <= running_o;
    end
  end

endmodule

`default_nettype wire

// ==== src/issue_ctrl.sv ====
// Admission and issue control

`default_nettype none

module issue_ctrl (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  seq_pkg::vreq_t                     req_i,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  input  seq_pkg::vinsn_set_t                running_i,
  input  logic [seq_pkg::NrUnits-1:0]        unit_full_i,
  input  seq_pkg::vinsn_set_t                hazard_vs1_i,
  input  seq_pkg::vinsn_set_t                hazard_vs2_i,
  input  seq_pkg::vinsn_set_t                hazard_vd_i,
  output logic                               accept_o,
  output seq_pkg::vid_t                      new_id_o,
  output logic [seq_pkg::NrUnits-1:0]        unit_accept_o,
  output seq_pkg::issue_t                    issue_o,
  output logic                               issue_valid_o
);

  import seq_pkg::*;

  logic   id_free;
  unit_e  tgt_unit;
  issue_t issue_d;

  //////////////////////////////////////////////////////////////////////
  // Next instruction ID
  //////////////////////////////////////////////////////////////////////

  // Lowest ID not running, scanned from the top
  always_comb begin
    new_id_o = '0;
    id_free  = 1'b0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_i[i]) begin
        new_id_o = vid_t'(i);
        id_free  = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Admission
  //////////////////////////////////////////////////////////////////////

  assign tgt_unit = unit_of(req_i.op);

  // Needs a free ID and room in the target unit
  assign req_ready_o = id_free & ~unit_full_i[tgt_unit];
  assign accept_o    = req_valid_i & req_ready_o;

  // Count-up strobe only for the target unit
  always_comb begin
    for (int unsigned u = 0; u < NrUnits; u++) begin
      unit_accept_o[u] = accept_o && (tgt_unit == unit_e'(u));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Issue register
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    issue_d = '{
      id:         new_id_o,
      unit:       tgt_unit,
      op:         req_i.op,
      vs1:        req_i.vs1,
      use_vs1:    req_i.use_vs1,
      vs2:        req_i.vs2,
      use_vs2:    req_i.use_vs2,
      vd:         req_i.vd,
      use_vd:     req_i.use_vd,
      hazard_vs1: hazard_vs1_i,
      hazard_vs2: hazard_vs2_i,
      hazard_vd:  hazard_vd_i
    };
  end

  // One-cycle pulse per accepted request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= accept_o;
    end
  end

  // Payload only meaningful with issue_valid_o
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      issue_o <= issue_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/vreg_scoreboard.sv ====
// Vector register scoreboard

`default_nettype none

module vreg_scoreboard (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  seq_pkg::vreq_t     req_i,
  input  logic               accept_i,
  input  seq_pkg::vid_t      new_id_i,
  input  seq_pkg::vinsn_set_t running_i,
  output seq_pkg::vinsn_set_t hazard_vs1_o,
  output seq_pkg::vinsn_set_t hazard_vs2_o,
  output seq_pkg::vinsn_set_t hazard_vd_o
);

  import seq_pkg::*;

  // Last instruction touching a register
  typedef struct packed {
    logic valid;
    vid_t id;
  } vreg_entry_t;

  vreg_entry_t [NrVRegs-1:0] reader_q, reader_d;
  vreg_entry_t [NrVRegs-1:0] writer_q, writer_d;

  // Entries of the current request's registers
  vreg_entry_t wr_vs1, wr_vs2, wr_vd, rd_vd;

  assign wr_vs1 = writer_q[req_i.vs1];
  assign wr_vs2 = writer_q[req_i.vs2];
  assign wr_vd  = writer_q[req_i.vd];
  assign rd_vd  = reader_q[req_i.vd];

  //////////////////////////////////////////////////////////////////////
  // Hazard vectors
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vd_o  = '0;
    // RAW, the entry only counts while its ID still runs
    if (req_i.use_vs1 && wr_vs1.valid && running_i[wr_vs1.id]) hazard_vs1_o[wr_vs1.id] = 1'b1;
    if (req_i.use_vs2 && wr_vs2.valid && running_i[wr_vs2.id]) hazard_vs2_o[wr_vs2.id] = 1'b1;
    if (req_i.use_vd) begin
      // WAR against the last reader of vd
      if (rd_vd.valid && running_i[rd_vd.id]) begin
        hazard_vs1_o[rd_vd.id] = 1'b1;
        hazard_vs2_o[rd_vd.id] = 1'b1;
      end
      // WAW against the last writer of vd
      if (wr_vd.valid && running_i[wr_vd.id]) hazard_vd_o[wr_vd.id] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // List update
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    reader_d = reader_q;
    writer_d = writer_q;
    // Expire entries of retired instructions
    for (int unsigned v = 0; v < NrVRegs; v++) begin
      reader_d[v].valid = reader_q[v].valid & running_i[reader_q[v].id];
      writer_d[v].valid = writer_q[v].valid & running_i[writer_q[v].id];
    end
    // New instruction takes over its registers
    if (accept_i) begin
      if (req_i.use_vd)  writer_d[req_i.vd]  = '{valid: 1'b1, id: new_id_i};
      if (req_i.use_vs1) reader_d[req_i.vs1] = '{valid: 1'b1, id: new_id_i};
      if (req_i.use_vs2) reader_d[req_i.vs2] = '{valid: 1'b1, id: new_id_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reader_q <= '0;
      writer_q <= '0;
    end else begin
      reader_q <= reader_d;
      writer_q <= writer_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/seq_pkg.sv ====
// Vector sequencer shared definitions

`default_nettype none

package seq_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Instructions in flight, one ID each
  localparam int unsigned NrVInsn = 8;
  // Architectural vector registers
  localparam int unsigned NrVRegs = 32;
  // ALU, multiplier, load unit, store unit
  localparam int unsigned NrUnits = 4;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  // One bit per instruction ID
  typedef logic [NrVInsn-1:0]         vinsn_set_t;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_AND   = 3'd2,
    OP_OR    = 3'd3,
    OP_MUL   = 3'd4,
    OP_MACC  = 3'd5,
    OP_LOAD  = 3'd6,
    OP_STORE = 3'd7
  } op_e;

  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MUL   = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  //////////////////////////////////////////////////////////////////////
  // Interface records
  //////////////////////////////////////////////////////////////////////

  // Request from the dispatcher
  typedef struct packed {
    op_e   op;
    vreg_t vs1;
    logic  use_vs1;
    vreg_t vs2;
    logic  use_vs2;
    vreg_t vd;
    logic  use_vd;
  } vreq_t;

  // Request towards the units, with hazards for chaining
  typedef struct packed {
    vid_t       id;
    unit_e      unit;
    op_e        op;
    vreg_t      vs1;
    logic       use_vs1;
    vreg_t      vs2;
    logic       use_vs2;
    vreg_t      vd;
    logic       use_vd;
    vinsn_set_t hazard_vs1;
    vinsn_set_t hazard_vs2;
    vinsn_set_t hazard_vd;
  } issue_t;

  // Completion pulse from one unit
  typedef struct packed {
    logic valid;
    vid_t id;
  } unit_done_t;

  // Each opcode runs on exactly one unit
  function automatic unit_e unit_of(op_e op);
    case (op)
      OP_MUL, OP_MACC: unit_of = UNIT_MUL;
      OP_LOAD:         unit_of = UNIT_LOAD;
      OP_STORE:        unit_of = UNIT_STORE;
      default:         unit_of = UNIT_ALU;
    endcase
  endfunction

endpackage

`default_nettype wire
